// ==== Makefile ====
# Verilator build and run for the AHB watch hub

VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= tb_ahb_watch
RTL_TOP   ?= ahb_watch_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SRCS := $(shell grep -v '^+' $(FILELIST)) include/ahb_watch_settings.svh
EXE  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	@grep -q '^Test OK$$' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/ahb_port_monitor.sv ====
// AHB per-port monitor
`timescale 1ns/1ps
`include "ahb_watch_settings.svh"

module ahb_port_monitor import ahb_watch_pkg::*; (
	input  logic   hclk,
	input  logic   rst_n,
	input  logic   addr_accept,
	input  haddr_t s_haddr,
	input  logic   s_hwrite,
	input  hsize_t s_hsize,
	input  hdata_t s_hwdata,
	input  logic   s_hready,
	input  hresp_t s_hresp,
	output count_t xfer_count,
	output count_t err_count,
	output logic   stall,
	output logic   wr_strobe,
	output haddr_t wr_addr,
	output hdata_t wr_data
);

	localparam int WAIT_LIMIT = `HREADY_WARN_WAIT_CNT;
	localparam int WAIT_W     = $clog2(WAIT_LIMIT + 1);

	logic              dp_active;
	logic              dp_write;
	haddr_t            dp_addr;
	logic [WAIT_W-1:0] wait_cnt;
	logic              complete;
	logic              waiting;

	assign complete = dp_active && s_hready;
	assign waiting  = dp_active && !s_hready;

	// a new address phase may be accepted in the same cycle the old data phase ends
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			dp_active <= 1'b0;
		end else if (addr_accept) begin
			dp_active <= 1'b1;
		end else if (complete) begin
			dp_active <= 1'b0;
		end
	end

	always_ff @(posedge hclk) begin
		if (addr_accept) begin
			dp_addr  <= s_haddr;
			dp_write <= s_hwrite;
		end
	end

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			xfer_count <= '0;
			err_count  <= '0;
			wr_strobe  <= 1'b0;
		end else begin
			wr_strobe <= complete && dp_write;
			if (complete && xfer_count != '1) begin
				xfer_count <= xfer_count + count_t'(1); // saturates instead of wrapping
			end
			if (complete && s_hresp == ERROR && err_count != '1) begin
				err_count <= err_count + count_t'(1);
			end
		end
	end

	always_ff @(posedge hclk) begin
		if (complete) begin
			wr_addr <= dp_addr;
			wr_data <= s_hwdata;
		end
	end

	// stall watchdog
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			wait_cnt <= '0;
			stall    <= 1'b0;
		end else begin
			if (!waiting) begin
				wait_cnt <= '0;
			end else if (wait_cnt != WAIT_W'(WAIT_LIMIT)) begin
				wait_cnt <= wait_cnt + WAIT_W'(1);
			end
			if (waiting && wait_cnt == WAIT_W'(WAIT_LIMIT - 1)) begin
				stall <= 1'b1; // sticky until reset
			end
		end
	end

	a_addr_aligned: assert property (@(posedge hclk) disable iff (!rst_n)
		addr_accept |-> addr_aligned(s_haddr, s_hsize))
		else $error("misaligned address %h for hsize %0d", s_haddr, s_hsize);

	a_err_in_data_phase: assert property (@(posedge hclk) disable iff (!rst_n)
		s_hresp == ERROR |-> dp_active)
		else $error("ERROR response outside a data phase");

	// counters only move upwards once reset is released
	a_count_monotonic: assert property (@(posedge hclk) disable iff (!rst_n)
		$past(rst_n) |-> xfer_count >= $past(xfer_count) && err_count >= $past(err_count))
		else $error("statistic counter went backwards");

endmodule

// ==== hdl/ahb_sim_control.sv ====
// Simulation control registers
`timescale 1ns/1ps
`include "ahb_watch_settings.svh"

module ahb_sim_control import ahb_watch_pkg::*; (
	input  logic       hclk,
	input  logic       rst_n,
	input  logic       wr_strobe [`NUM_PORTS],
	input  haddr_t     wr_addr   [`NUM_PORTS],
	input  hdata_t     wr_data   [`NUM_PORTS],
	output logic       sim_done,
	output logic       sim_pass,
	output logic [7:0] sim_code,
	output hart_mask_t harts_done
);

	localparam haddr_t FINISH_ADDR = haddr_t'(`SIM_CTRL_BASE);
	localparam haddr_t HART_ADDR   = FINISH_ADDR + haddr_t'(4);

	logic       fin_hit;
	logic [7:0] fin_code;
	hart_mask_t hart_set;
	hart_mask_t hart_next;

	always_comb begin
		fin_hit  = 1'b0;
		fin_code = '0;
		hart_set = '0;
		for (int i = `NUM_PORTS - 1; i >= 0; i--) begin // walk downwards so the lowest port wins
			if (wr_strobe[i] && wr_addr[i] == FINISH_ADDR) begin
				fin_hit  = 1'b1;
				fin_code = wr_data[i][7:0];
			end
			if (wr_strobe[i] && wr_addr[i] == HART_ADDR) begin
				hart_set = hart_set | wr_data[i][`RUN_HART_NUM-1:0];
			end
		end
	end

	assign hart_next = harts_done | hart_set;

	// a finish write outranks the hart-done path in the same cycle
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			sim_done   <= 1'b0;
			sim_pass   <= 1'b0;
			sim_code   <= '0;
			harts_done <= '0;
		end else if (!sim_done) begin
			harts_done <= hart_next;
			if (fin_hit) begin
				sim_done <= 1'b1;
				sim_pass <= fin_code == `SIM_PASS_CODE;
				sim_code <= fin_code;
			end else if (&hart_next) begin
				sim_done <= 1'b1; // every hart has reported
				sim_pass <= 1'b1;
				sim_code <= `SIM_PASS_CODE;
			end
		end
	end

	a_done_sticky: assert property (@(posedge hclk) disable iff (!rst_n)
		sim_done |=> sim_done)
		else $error("sim_done dropped without a reset");

endmodule

// ==== hdl/ahb_tap_sampler.sv ====
// AHB bus tap register stage
`timescale 1ns/1ps
`include "ahb_watch_settings.svh"

module ahb_tap_sampler import ahb_watch_pkg::*; (
	input  logic    hclk,
	input  logic    rst_n,
	input  haddr_t  haddr       [`NUM_PORTS],
	input  htrans_t htrans      [`NUM_PORTS],
	input  logic    hwrite      [`NUM_PORTS],
	input  hsize_t  hsize       [`NUM_PORTS],
	input  hdata_t  hwdata      [`NUM_PORTS],
	input  logic    hready      [`NUM_PORTS],
	input  hresp_t  hresp       [`NUM_PORTS],
	output logic    addr_accept [`NUM_PORTS],
	output haddr_t  s_haddr     [`NUM_PORTS],
	output logic    s_hwrite    [`NUM_PORTS],
	output hsize_t  s_hsize     [`NUM_PORTS],
	output hdata_t  s_hwdata    [`NUM_PORTS],
	output logic    s_hready    [`NUM_PORTS],
	output hresp_t  s_hresp     [`NUM_PORTS]
);

	htrans_t s_htrans [`NUM_PORTS];

	// bus handshake signals come out of reset in the idle, ready state
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_PORTS; i++) begin
				s_htrans[i] <= IDLE;
				s_hready[i] <= 1'b1;
				s_hresp[i]  <= OKAY;
			end
		end else begin
			s_htrans <= htrans;
			s_hready <= hready;
			s_hresp  <= hresp;
		end
	end

	always_ff @(posedge hclk) begin
		s_haddr  <= haddr;
		s_hwrite <= hwrite;
		s_hsize  <= hsize;
		s_hwdata <= hwdata;
	end

	always_comb begin
		for (int i = 0; i < `NUM_PORTS; i++) begin
			addr_accept[i] = (s_htrans[i] == NONSEQ || s_htrans[i] == SEQ)
				&& s_hready[i]; // busy and idle carry no transfer
		end
	end

endmodule

// ==== hdl/ahb_watch_pkg.sv ====
// AHB watch hub types
`include "ahb_watch_settings.svh"

package ahb_watch_pkg;

	typedef logic [`AHB_ADDR_WIDTH-1:0] haddr_t;
	typedef logic [`AHB_DATA_WIDTH-1:0] hdata_t;
	typedef logic [`COUNT_WIDTH-1:0]    count_t;
	typedef logic [2:0]                 hsize_t;   // log2 of the transfer size in bytes
	typedef logic [`RUN_HART_NUM-1:0]   hart_mask_t;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// only the two AHB-Lite responses are modelled
	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_t;

	// true when the address sits on a boundary of its transfer size
	function automatic logic addr_aligned(haddr_t addr, hsize_t size);
		haddr_t mask;
		mask = (haddr_t'(1) << size) - haddr_t'(1);
		return (addr & mask) == '0;
	endfunction

endpackage

// ==== hdl/ahb_watch_top.sv ====
// AHB watch hub top level
`timescale 1ns/1ps
`include "ahb_watch_settings.svh"

module ahb_watch_top import ahb_watch_pkg::*; (
	input  logic       hclk,
	input  logic       rst_n,
	input  haddr_t     haddr      [`NUM_PORTS],
	input  htrans_t    htrans     [`NUM_PORTS],
	input  logic       hwrite     [`NUM_PORTS],
	input  hsize_t     hsize      [`NUM_PORTS],
	input  hdata_t     hwdata     [`NUM_PORTS],
	input  logic       hready     [`NUM_PORTS],
	input  hresp_t     hresp      [`NUM_PORTS],
	output count_t     xfer_count [`NUM_PORTS],
	output count_t     err_count  [`NUM_PORTS],
	output logic       stall      [`NUM_PORTS],
	output logic       sim_done,
	output logic       sim_pass,
	output logic [7:0] sim_code,
	output hart_mask_t harts_done
);

	logic   addr_accept [`NUM_PORTS];
	haddr_t s_haddr     [`NUM_PORTS];
	logic   s_hwrite    [`NUM_PORTS];
	hsize_t s_hsize     [`NUM_PORTS];
	hdata_t s_hwdata    [`NUM_PORTS];
	logic   s_hready    [`NUM_PORTS];
	hresp_t s_hresp     [`NUM_PORTS];
	logic   wr_strobe   [`NUM_PORTS];
	haddr_t wr_addr     [`NUM_PORTS];
	hdata_t wr_data     [`NUM_PORTS];

	ahb_tap_sampler ahb_tap_sampler (
		.hclk       (hclk       ),
		.rst_n      (rst_n      ),
		.haddr      (haddr      ),
		.htrans     (htrans     ),
		.hwrite     (hwrite     ),
		.hsize      (hsize      ),
		.hwdata     (hwdata     ),
		.hready     (hready     ),
		.hresp      (hresp      ),
		.addr_accept(addr_accept),
		.s_haddr    (s_haddr    ),
		.s_hwrite   (s_hwrite   ),
		.s_hsize    (s_hsize    ),
		.s_hwdata   (s_hwdata   ),
		.s_hready   (s_hready   ),
		.s_hresp    (s_hresp    )
	);

	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
		ahb_port_monitor ahb_port_monitor (
			.hclk       (hclk          ),
			.rst_n      (rst_n         ),
			.addr_accept(addr_accept[i]),
			.s_haddr    (s_haddr[i]    ),
			.s_hwrite   (s_hwrite[i]   ),
			.s_hsize    (s_hsize[i]    ),
			.s_hwdata   (s_hwdata[i]   ),
			.s_hready   (s_hready[i]   ),
			.s_hresp    (s_hresp[i]    ),
			.xfer_count (xfer_count[i] ),
			.err_count  (err_count[i]  ),
			.stall      (stall[i]      ),
			.wr_strobe  (wr_strobe[i]  ),
			.wr_addr    (wr_addr[i]    ),
			.wr_data    (wr_data[i]    )
		);
	end

	ahb_sim_control ahb_sim_control (
		.hclk      (hclk      ),
		.rst_n     (rst_n     ),
		.wr_strobe (wr_strobe ),
		.wr_addr   (wr_addr   ),
		.wr_data   (wr_data   ),
		.sim_done  (sim_done  ),
		.sim_pass  (sim_pass  ),
		.sim_code  (sim_code  ),
		.harts_done(harts_done)
	);

endmodule

// ==== include/ahb_watch_settings.svh ====
// AHB watch hub settings
`ifndef AHB_WATCH_SETTINGS_SVH
`define AHB_WATCH_SETTINGS_SVH

// bus widths
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// number of bus ports watched in parallel
`define NUM_PORTS 2

// width of the per-port transfer and error counters
`define COUNT_WIDTH 16

// consecutive data-phase wait cycles that raise the stall flag
`define HREADY_WARN_WAIT_CNT 16

// simulation-control window
`define SIM_CTRL_BASE 32'h0008_0000

// finish code reported as a passing run
`define SIM_PASS_CODE 8'h5A

// harts that have to report done before the run ends
`define RUN_HART_NUM 2

`endif

// ==== sim.f ====
+incdir+include
hdl/ahb_watch_pkg.sv
hdl/ahb_tap_sampler.sv
hdl/ahb_port_monitor.sv
hdl/ahb_sim_control.sv
hdl/ahb_watch_top.sv
testbench/tb_ahb_watch.sv

// ==== testbench/tb_ahb_watch.sv ====
// AHB watch hub testbench
`timescale 1ns/1ps
`include "ahb_watch_settings.svh"

module tb_ahb_watch import ahb_watch_pkg::*; ();

	localparam int         RAND_XFERS  = 24;
	localparam int         BURST_LEN   = 6;
	localparam int         WAIT_LIMIT  = 40;
	localparam int         STALL_WAITS = `HREADY_WARN_WAIT_CNT;
	localparam haddr_t     FINISH_ADDR = haddr_t'(`SIM_CTRL_BASE);
	localparam haddr_t     HART_ADDR   = FINISH_ADDR + haddr_t'(4);
	localparam logic [7:0] FAIL_CODE   = 8'h3C;

	logic       hclk;
	logic       rst_n;
	haddr_t     haddr      [`NUM_PORTS];
	htrans_t    htrans     [`NUM_PORTS];
	logic       hwrite     [`NUM_PORTS];
	hsize_t     hsize      [`NUM_PORTS];
	hdata_t     hwdata     [`NUM_PORTS];
	logic       hready     [`NUM_PORTS];
	hresp_t     hresp      [`NUM_PORTS];
	count_t     xfer_count [`NUM_PORTS];
	count_t     err_count  [`NUM_PORTS];
	logic       stall      [`NUM_PORTS];
	logic       sim_done;
	logic       sim_pass;
	logic [7:0] sim_code;
	hart_mask_t harts_done;

	int          errors;
	int          timeouts;
	int          exp_xfer [`NUM_PORTS];
	int          exp_err  [`NUM_PORTS];
	logic [31:0] lcg_state;

	ahb_watch_top uut (
		.hclk      (hclk      ),
		.rst_n     (rst_n     ),
		.haddr     (haddr     ),
		.htrans    (htrans    ),
		.hwrite    (hwrite    ),
		.hsize     (hsize     ),
		.hwdata    (hwdata    ),
		.hready    (hready    ),
		.hresp     (hresp     ),
		.xfer_count(xfer_count),
		.err_count (err_count ),
		.stall     (stall     ),
		.sim_done  (sim_done  ),
		.sim_pass  (sim_pass  ),
		.sim_code  (sim_code  ),
		.harts_done(harts_done)
	);

	always #20 hclk = ~hclk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s: got %0h, expected %0h", $time, msg, actual, expected);
			errors++;
		end
	endtask

	task automatic drive_idle(input int port);
		htrans[port] = IDLE;
		hready[port] = 1'b1;
		hresp[port]  = OKAY;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (2) @(negedge hclk);
		rst_n = 1'b1;
		for (int p = 0; p < `NUM_PORTS; p++) begin
			exp_xfer[p] = 0;
			exp_err[p]  = 0;
		end
	endtask

	// one address phase, then a data phase stretched by the given waits
	task automatic ahb_xfer(input int port, input logic write, input haddr_t addr,
			input hdata_t data, input hsize_t size, input int waits, input hresp_t resp);
		@(negedge hclk);
		htrans[port] = NONSEQ;
		haddr[port]  = addr;
		hwrite[port] = write;
		hsize[port]  = size;
		hready[port] = 1'b1;
		hresp[port]  = OKAY;
		for (int w = 0; w < waits; w++) begin
			@(negedge hclk);
			htrans[port] = IDLE;
			hwdata[port] = data;
			hready[port] = 1'b0;
		end
		@(negedge hclk);
		htrans[port] = IDLE;
		hwdata[port] = data;
		hready[port] = 1'b1;
		hresp[port]  = resp; // the response only counts in the completing cycle
		@(negedge hclk);
		drive_idle(port);
		exp_xfer[port]++;
		if (resp == ERROR) begin
			exp_err[port]++;
		end
	endtask

	task automatic ahb_write(input int port, input haddr_t addr, input hdata_t data,
			input int waits, input hresp_t resp);
		ahb_xfer(port, 1'b1, addr, data, hsize_t'(2), waits, resp);
	endtask

	task automatic ahb_read(input int port, input haddr_t addr, input hsize_t size,
			input int waits, input hresp_t resp);
		ahb_xfer(port, 1'b0, addr, lcg_next(), size, waits, resp);
	endtask

	// each new address phase overlaps the data phase of the previous beat
	task automatic ahb_burst(input int port, input logic write, input haddr_t base, input int len);
		for (int k = 0; k < len; k++) begin
			@(negedge hclk);
			htrans[port] = (k == 0) ? NONSEQ : SEQ;
			haddr[port]  = base + haddr_t'(4 * k);
			hwrite[port] = write;
			hsize[port]  = hsize_t'(2);
			hwdata[port] = lcg_next();
			hready[port] = 1'b1;
		end
		@(negedge hclk);
		htrans[port] = IDLE;
		hwdata[port] = lcg_next();
		@(negedge hclk);
		drive_idle(port);
		exp_xfer[port] += len;
	endtask

	task automatic wait_xfer(input int port);
		int cycles;
		cycles = 0;
		while (int'(xfer_count[port]) != exp_xfer[port] && cycles < WAIT_LIMIT) begin
			@(negedge hclk);
			cycles++;
		end
		if (int'(xfer_count[port]) != exp_xfer[port]) begin
			$display("Timeout: port %0d transfer count stayed at %0d instead of reaching %0d",
				port, xfer_count[port], exp_xfer[port]);
			timeouts++;
		end
	endtask

	task automatic wait_harts(input hart_mask_t mask);
		int cycles;
		cycles = 0;
		while (harts_done != mask && cycles < WAIT_LIMIT) begin
			@(negedge hclk);
			cycles++;
		end
		if (harts_done != mask) begin
			$display("Timeout: hart done mask never became %0h", mask);
			timeouts++;
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!sim_done && cycles < WAIT_LIMIT) begin
			@(negedge hclk);
			cycles++;
		end
		if (!sim_done) begin
			$display("Timeout: the run was never marked done");
			timeouts++;
		end
	endtask

	task automatic check_counts(input string msg);
		for (int p = 0; p < `NUM_PORTS; p++) begin
			check(32'(xfer_count[p]), exp_xfer[p], $sformatf("%s, port %0d xfer_count", msg, p));
			check(32'(err_count[p]), exp_err[p], $sformatf("%s, port %0d err_count", msg, p));
		end
	endtask

	task automatic test_reset_values();
		check_counts("after reset");
		for (int p = 0; p < `NUM_PORTS; p++) begin
			check(32'(stall[p]), 0, $sformatf("after reset, port %0d stall", p));
		end
		check(32'(sim_done), 0, "after reset, sim_done");
		check(32'(sim_pass), 0, "after reset, sim_pass");
		check(32'(sim_code), 0, "after reset, sim_code");
		check(32'(harts_done), 0, "after reset, harts_done");
	endtask

	task automatic test_random_traffic();
		logic [31:0] r;
		int          port;
		int          waits;
		haddr_t      addr;
		hsize_t      size;
		for (int i = 0; i < RAND_XFERS * `NUM_PORTS; i++) begin
			r     = lcg_next();
			port  = int'(r[31:24]) % `NUM_PORTS;
			waits = (r[19:18] == 2'd0) ? int'(r[17:16]) + 1 : 0; // a quarter of them stall a bit
			size  = (r[21:20] == 2'd3) ? hsize_t'(2) : hsize_t'(r[21:20]);
			addr  = 32'h1000_0000 | (lcg_next() & 32'h0000_fff0);
			if (r[23]) begin
				ahb_write(port, addr, lcg_next(), waits, OKAY);
			end else begin
				ahb_read(port, addr, size, waits, OKAY);
			end
			wait_xfer(port);
			check_counts("random traffic");
		end
		for (int p = 0; p < `NUM_PORTS; p++) begin
			ahb_burst(p, p[0], 32'h2000_0000, BURST_LEN);
			wait_xfer(p);
			check_counts("pipelined burst");
		end
	endtask

	task automatic test_error_responses();
		hresp_t resp;
		int     port;
		for (int i = 0; i < 7; i++) begin
			port = i % `NUM_PORTS;
			resp = (i % 3 != 2) ? ERROR : OKAY;
			if (i[0]) begin
				ahb_read(port, 32'h1800_0000 + haddr_t'(4 * i), hsize_t'(2), i % 3, resp);
			end else begin
				ahb_write(port, 32'h1800_0000 + haddr_t'(4 * i), lcg_next(), i % 3, resp);
			end
			wait_xfer(port);
			check_counts("error responses");
		end
	endtask

	task automatic test_stall();
		ahb_write(0, 32'h3000_0000, lcg_next(), STALL_WAITS - 1, OKAY);
		wait_xfer(0);
		check(32'(stall[0]), 0, "stall after one wait less than the limit");
		ahb_read(1, 32'h3000_0010, hsize_t'(2), STALL_WAITS, OKAY);
		wait_xfer(1);
		check(32'(stall[1]), 1, "stall after waits at the limit");
		check(32'(stall[0]), 0, "stall on the quiet port");
		ahb_write(1, 32'h3000_0020, lcg_next(), 0, OKAY);
		wait_xfer(1);
		check(32'(stall[1]), 1, "stall stays set");
		check_counts("stall test");
	endtask

	task automatic test_hart_done();
		hart_mask_t mask;
		mask = '0;
		for (int h = 0; h < `RUN_HART_NUM; h++) begin
			mask = mask | (hart_mask_t'(1) << h);
			ahb_write(h % `NUM_PORTS, HART_ADDR, hdata_t'(1) << h, h % 2, OKAY);
			if (h < `RUN_HART_NUM - 1) begin
				wait_harts(mask);
				check(32'(sim_done), 0, "sim_done before the last hart");
				check(32'(sim_pass), 0, "sim_pass before the last hart");
			end else begin
				wait_done();
				check(32'(harts_done), 32'(mask), "harts_done after the last hart");
				check(32'(sim_pass), 1, "sim_pass after the last hart");
				check(32'(sim_code), 32'(`SIM_PASS_CODE), "sim_code after the last hart");
			end
		end
	endtask

	task automatic test_finish_codes();
		apply_reset();
		test_reset_values();
		ahb_write(1, FINISH_ADDR, {24'h0, FAIL_CODE}, 1, OKAY);
		wait_done();
		check(32'(sim_pass), 0, "sim_pass after a failing finish code");
		check(32'(sim_code), 32'(FAIL_CODE), "sim_code after a failing finish code");
		ahb_write(0, FINISH_ADDR, {24'h0, `SIM_PASS_CODE}, 0, OKAY);
		wait_xfer(0);
		repeat (2) @(negedge hclk); // control registers trail the monitor by one cycle
		check(32'(sim_done), 1, "sim_done after a second finish write");
		check(32'(sim_pass), 0, "sim_pass frozen after the run ended");
		check(32'(sim_code), 32'(FAIL_CODE), "sim_code frozen after the run ended");
	endtask

	initial begin
		hclk      = 1'b0;
		errors    = 0;
		timeouts  = 0;
		lcg_state = 32'd61;
		for (int p = 0; p < `NUM_PORTS; p++) begin
			haddr[p]  = '0;
			hwrite[p] = 1'b0;
			hsize[p]  = '0;
			hwdata[p] = '0;
			drive_idle(p);
		end
		apply_reset();
		test_reset_values();
		test_random_traffic();
		test_error_responses();
		test_stall();
		test_hart_done();
		test_finish_codes();
		$display("check errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
